/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       := tb_recovery
FILELIST  := sources.f
PASS_MSG  := Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

/* dv/recovery_tests.svh */
// Test table rows, command geometry lookup and LFSR step function

typedef struct packed {
  logic [7:0]  cmd;
  logic        is_rd;
  logic [15:0] len;
  logic        err;
  logic [7:0]  abort_at;
  logic [2:0]  npay;
  logic [31:0] pay0;
  logic [31:0] pay1;
  logic [31:0] pay2;
  logic [7:0]  code;
} test_row_t;

localparam int NUM_TESTS = 20;

// cmd, read, len, error, abort cycle, push count, payload words, expected code
// Pushes past the third word repeat the last payload word
localparam test_row_t TESTS [NUM_TESTS] = '{
  '{8'd34, 1'b1, 16'd15, 1'b0, 8'd0, 3'd0, 32'h0, 32'h0, 32'h0, 8'h00},
  '{8'd35, 1'b1, 16'd24, 1'b0, 8'd0, 3'd0, 32'h0, 32'h0, 32'h0, 8'h00},
  '{8'd38, 1'b0, 16'd3, 1'b0, 8'd0, 3'd1, 32'hC0DE_1234, 32'h0, 32'h0, 8'h00},
  '{8'd38, 1'b1, 16'd3, 1'b0, 8'd0, 3'd0, 32'h0, 32'h0, 32'h0, 8'h00},
  '{8'd36, 1'b1, 16'd8, 1'b0, 8'd0, 3'd0, 32'h0, 32'h0, 32'h0, 8'h00},
  '{8'd35, 1'b0, 16'd8, 1'b0, 8'd0, 3'd2, 32'hDEAD_BEEF, 32'h1357_9BDF, 32'h0, 8'h01},
  '{8'd36, 1'b1, 16'd8, 1'b0, 8'd0, 3'd0, 32'h0, 32'h0, 32'h0, 8'h00},
  '{8'd35, 1'b1, 16'd24, 1'b0, 8'd0, 3'd0, 32'h0, 32'h0, 32'h0, 8'h00},
  '{8'd37, 1'b0, 16'd8, 1'b1, 8'd0, 3'd5, 32'h1111_2222, 32'h3333_4444, 32'h5555_6666,
    8'h04},
  '{8'd36, 1'b1, 16'd8, 1'b0, 8'd0, 3'd0, 32'h0, 32'h0, 32'h0, 8'h00},
  '{8'd50, 1'b0, 16'd0, 1'b0, 8'd0, 3'd0, 32'h0, 32'h0, 32'h0, 8'h02},
  '{8'd36, 1'b1, 16'd8, 1'b0, 8'd0, 3'd0, 32'h0, 32'h0, 32'h0, 8'h00},
  '{8'd38, 1'b0, 16'd12, 1'b0, 8'd0, 3'd3, 32'hA1A2_A3A4, 32'hB1B2_B3B4, 32'hC1C2_C3C4,
    8'h03},
  '{8'd36, 1'b1, 16'd8, 1'b0, 8'd0, 3'd0, 32'h0, 32'h0, 32'h0, 8'h00},
  '{8'd37, 1'b1, 16'd3, 1'b0, 8'd0, 3'd0, 32'h0, 32'h0, 32'h0, 8'h00},
  '{8'd46, 1'b1, 16'd20, 1'b0, 8'd4, 3'd0, 32'h0, 32'h0, 32'h0, 8'h00},
  '{8'd46, 1'b1, 16'd20, 1'b0, 8'd0, 3'd0, 32'h0, 32'h0, 32'h0, 8'h00},
  '{8'd45, 1'b0, 16'd8, 1'b0, 8'd0, 3'd2, 32'h0F0F_0F0F, 32'h8765_4321, 32'h0, 8'h00},
  '{8'd45, 1'b1, 16'd6, 1'b0, 8'd0, 3'd0, 32'h0, 32'h0, 32'h0, 8'h00},
  '{8'd40, 1'b1, 16'd4, 1'b0, 8'd0, 3'd0, 32'h0, 32'h0, 32'h0, 8'h00}
};

// Start word and response length per command code, zero when unknown
function automatic logic lookup_cmd(input logic [7:0] code, output int start, output int len);
  start = 0;
  len   = 0;
  case (code)
    8'd34: begin start = 0;  len = 15; end
    8'd35: begin start = 4;  len = 24; end
    8'd36: begin start = 11; len = 8;  end
    8'd37: begin start = 13; len = 3;  end
    8'd38: begin start = 14; len = 3;  end
    8'd39: begin start = 15; len = 2;  end
    8'd40: begin start = 16; len = 4;  end
    8'd45: begin start = 17; len = 6;  end
    8'd46: begin start = 19; len = 20; end
    default: return 1'b0;
  endcase
  return 1'b1;
endfunction

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

/* dv/recovery_checker.sv */
// Response, done, queue and control output checker with register shadow
`timescale 1ns/1ns

module recovery_checker (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  int          row_i,
  input  logic        cmd_valid_i,
  input  logic        cmd_done_i,
  input  logic        res_valid_i,
  input  logic [15:0] res_len_i,
  input  logic        res_dvalid_i,
  input  logic        res_dready_i,
  input  logic [7:0]  res_data_i,
  input  logic        res_dlast_i,
  input  logic        rx_empty_i,
  input  logic        rx_full_i,
  input  logic        rx_req_i,
  input  logic        rx_queue_clr_i,
  input  logic [31:0] device_reset_i,
  input  logic [31:0] recovery_ctrl_i,
  input  logic [31:0] fifo_ctrl_0_i,
  input  logic [31:0] fifo_ctrl_1_i,
  output int          rows_done_o,
  output int          rows_failed_o
);
  import recovery_pkg::*;
  import recovery_csr_pkg::*;
  `include "recovery_tests.svh"

  csr_word_t shadow [CSR_NUM_WORDS];
  test_row_t row;
  int        start_w;
  int        len_b;
  int        nbytes;
  int        row_errs;
  int        req_cycles;
  int        clr_cycles;
  logic      known;
  logic      len_seen;
  logic      last_seen;

  initial begin
    rows_done_o   = 0;
    rows_failed_o = 0;
    req_cycles    = 0;
    clr_cycles    = 0;
    for (int i = 0; i < CSR_NUM_WORDS; i++) begin
      shadow[i] = CSR_RESET[i];
    end
  end

  function automatic logic [7:0] expected_byte(input int k);
    return shadow[start_w + k / 4][8 * (k % 4) +: 8];
  endfunction

  function automatic logic [31:0] payload_word(input int k);
    return (k == 0) ? row.pay0 : (k == 1) ? row.pay1 : row.pay2;
  endfunction

  task automatic report_mismatch(input string sig, input logic [31:0] exp, input logic [31:0] got);
    $display("MISMATCH t=%0t %s expected 0x%0h got 0x%0h", $time, sig, exp, got);
    row_errs++;
  endtask

  task automatic report_failure(input string what);
    $display("ERROR t=%0t row %0d: %s", $time, row_i, what);
    row_errs++;
  endtask

  // Words beyond the group or on read-only words never land
  task automatic apply_writes();
    int nwords;
    int group;
    nwords = (int'(row.len) + 3) / 4;
    group  = (len_b + 3) / 4;
    for (int k = 0; k < nwords; k++) begin
      if (k < group && CSR_WRITABLE[start_w + k])
        shadow[start_w + k] = payload_word(k);
    end
  endtask

  task automatic finish_row();
    int exp_req;
    int exp_clr;
    if (row.is_rd && known && !row.err) begin
      if (!len_seen)
        report_failure("no length announcement before command end");
      if (row.abort_at != 0) begin
        if (last_seen)
          report_failure("res_dlast_o seen on an aborted read");
        if (nbytes >= len_b)
          report_failure("aborted read still delivered every byte");
      end else if (nbytes != len_b) begin
        report_failure($sformatf("read delivered %0d of %0d bytes", nbytes, len_b));
      end
    end else begin
      if (len_seen || nbytes != 0)
        report_failure("response stream on a command without read data");
      if (!rx_empty_i)
        report_failure("receive queue not empty at command end");
      if (known && !row.err)
        apply_writes();
    end
    // One pop per payload word, one queue clear per error or abort
    exp_req = (!row.is_rd && known && !row.err) ? (int'(row.len) + 3) / 4 : 0;
    exp_clr = (row.err || !known || row.abort_at != 0) ? 1 : 0;
    if (req_cycles != exp_req)
      report_mismatch("rx_req_o cycles", 32'(exp_req), 32'(req_cycles));
    if (clr_cycles != exp_clr)
      report_mismatch("rx_queue_clr_o cycles", 32'(exp_clr), 32'(clr_cycles));
    req_cycles = 0;
    clr_cycles = 0;
    shadow[CSR_DEVICE_STATUS_0][15:8] = row.code;
    if (recovery_ctrl_i != shadow[CSR_RECOVERY_CTRL])
      report_mismatch("recovery_ctrl_o", shadow[CSR_RECOVERY_CTRL], recovery_ctrl_i);
    if (device_reset_i != shadow[CSR_DEVICE_RESET])
      report_mismatch("device_reset_o", shadow[CSR_DEVICE_RESET], device_reset_i);
    if (fifo_ctrl_0_i != shadow[CSR_INDIRECT_FIFO_CTRL_0])
      report_mismatch("fifo_ctrl_0_o", shadow[CSR_INDIRECT_FIFO_CTRL_0], fifo_ctrl_0_i);
    if (fifo_ctrl_1_i != shadow[CSR_INDIRECT_FIFO_CTRL_1])
      report_mismatch("fifo_ctrl_1_o", shadow[CSR_INDIRECT_FIFO_CTRL_1], fifo_ctrl_1_i);
    rows_done_o++;
    if (row_errs != 0)
      rows_failed_o++;
    $display("Row %0d cmd %0d %s len %0d: %s", row_i, row.cmd, row.is_rd ? "read" : "write",
             row.len, (row_errs == 0) ? "ok" : "FAILED");
  endtask

  // Sampled mid-cycle, away from the driving edge
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (cmd_valid_i) begin
        row       = TESTS[row_i];
        known     = lookup_cmd(row.cmd, start_w, len_b);
        nbytes    = 0;
        row_errs  = 0;
        len_seen  = 1'b0;
        last_seen = 1'b0;
        // Queue holds every pushed word up to four, extra pushes dropped
        if (rx_full_i != (row.npay >= 3'd4))
          report_mismatch("rx_full_o", 32'(row.npay >= 3'd4), 32'(rx_full_i));
        if (rx_empty_i != (row.npay == 3'd0))
          report_mismatch("rx_empty_o", 32'(row.npay == 3'd0), 32'(rx_empty_i));
      end
      if (rx_req_i)
        req_cycles++;
      if (rx_queue_clr_i)
        clr_cycles++;
      if (res_valid_i) begin
        len_seen = 1'b1;
        if (res_len_i != 16'(len_b))
          report_mismatch("res_len_o", 32'(len_b), 32'(res_len_i));
      end
      if (res_dvalid_i && res_dready_i) begin
        if (nbytes >= len_b) begin
          report_failure("byte accepted past the response length");
        end else begin
          if (res_data_i != expected_byte(nbytes))
            report_mismatch("res_data_o", 32'(expected_byte(nbytes)), 32'(res_data_i));
          if (res_dlast_i != (nbytes == len_b - 1))
            report_mismatch("res_dlast_o", 32'(nbytes == len_b - 1), 32'(res_dlast_i));
        end
        if (res_dlast_i)
          last_seen = 1'b1;
        nbytes++;
      end
      if (cmd_done_i)
        finish_row();
    end
  end

endmodule

/* dv/tb_clk_gen.sv */
// Testbench clock and reset generator
`timescale 1ns/1ns

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    // Reset held for two rising edges
    repeat (2) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

  always #5 clk_o = ~clk_o;

endmodule

/* dv/tb_recovery.sv */
// Testbench top: DUT, queue feeding, table loop, back-pressure, watchdog and verdict
`timescale 1ns/1ns

module tb_recovery;
  import recovery_pkg::*;
  import recovery_csr_pkg::*;
  `include "recovery_tests.svh"

  localparam int WATCHDOG_NS = (NUM_TESTS * 200 + 10) * 10;

  logic        clk_i;
  logic        rst_ni;
  logic        cmd_valid_i;
  logic        cmd_is_rd_i;
  command_e    cmd_cmd_i;
  cmd_len_t    cmd_len_i;
  logic        cmd_error_i;
  logic        cmd_done_o;
  logic        res_valid_o;
  logic        res_ready_i;
  cmd_len_t    res_len_o;
  logic        res_dvalid_o;
  logic        res_dready_i;
  res_byte_t   res_data_o;
  logic        res_dlast_o;
  logic        rx_wvalid_i;
  csr_word_t   rx_wdata_i;
  logic        rx_full_o;
  logic        rx_empty_o;
  logic        rx_req_o;
  logic        rx_queue_clr_o;
  logic        host_abort_i;
  csr_word_t   device_reset_o;
  csr_word_t   recovery_ctrl_o;
  csr_word_t   fifo_ctrl_0_o;
  csr_word_t   fifo_ctrl_1_o;
  int          row_idx;
  int          rows_done;
  int          rows_failed;
  logic [31:0] lfsr_q;

  tb_clk_gen u_clk_gen (.clk_o(clk_i), .rst_no(rst_ni));

  recovery_top i_dut (.*);

  recovery_checker u_checker (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .row_i           (row_idx),
    .cmd_valid_i     (cmd_valid_i),
    .cmd_done_i      (cmd_done_o),
    .res_valid_i     (res_valid_o),
    .res_len_i       (res_len_o),
    .res_dvalid_i    (res_dvalid_o),
    .res_dready_i    (res_dready_i),
    .res_data_i      (res_data_o),
    .res_dlast_i     (res_dlast_o),
    .rx_empty_i      (rx_empty_o),
    .rx_full_i       (rx_full_o),
    .rx_req_i        (rx_req_o),
    .rx_queue_clr_i  (rx_queue_clr_o),
    .device_reset_i  (device_reset_o),
    .recovery_ctrl_i (recovery_ctrl_o),
    .fifo_ctrl_0_i   (fifo_ctrl_0_o),
    .fifo_ctrl_1_i   (fifo_ctrl_1_o),
    .rows_done_o     (rows_done),
    .rows_failed_o   (rows_failed)
  );

  // Random data back-pressure, one LFSR step per cycle
  always @(posedge clk_i) begin
    #1;
    lfsr_q       = lfsr_step(lfsr_q);
    res_dready_i = lfsr_q[0];
  end

  task automatic push_word(input csr_word_t w);
    @(posedge clk_i);
    #1;
    rx_wvalid_i = 1'b1;
    rx_wdata_i  = w;
  endtask

  task automatic run_row(input int i);
    test_row_t r;
    r = TESTS[i];
    for (int k = 0; k < int'(r.npay); k++) begin
      push_word((k == 0) ? r.pay0 : (k == 1) ? r.pay1 : r.pay2);
    end
    @(posedge clk_i);
    #1;
    rx_wvalid_i = 1'b0;
    row_idx     = i;
    cmd_valid_i = 1'b1;
    cmd_is_rd_i = r.is_rd;
    cmd_cmd_i   = command_e'(r.cmd);
    cmd_len_i   = r.len;
    cmd_error_i = r.err;
    @(posedge clk_i);
    #1;
    cmd_valid_i = 1'b0;
    if (r.abort_at != 0) begin
      do @(negedge clk_i); while (!res_valid_o);
      repeat (int'(r.abort_at)) @(posedge clk_i);
      #1 host_abort_i = 1'b1;
    end
    do @(negedge clk_i); while (!cmd_done_o);
    @(posedge clk_i);
    #1 host_abort_i = 1'b0;
  endtask

  initial begin
    lfsr_q       = 32'hd648b2f5;
    row_idx      = 0;
    cmd_valid_i  = 1'b0;
    cmd_is_rd_i  = 1'b0;
    cmd_cmd_i    = CMD_PROT_CAP;
    cmd_len_i    = '0;
    cmd_error_i  = 1'b0;
    res_ready_i  = 1'b1;
    res_dready_i = 1'b0;
    rx_wvalid_i  = 1'b0;
    rx_wdata_i   = '0;
    host_abort_i = 1'b0;
    wait (rst_ni === 1'b1);
    for (int i = 0; i < NUM_TESTS; i++) begin
      run_row(i);
    end
    repeat (2) @(posedge clk_i);
    $display("Rows run: %0d, failed: %0d", rows_done, rows_failed);
    if (rows_failed == 0 && rows_done == NUM_TESTS) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the test table finished");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* rtl/recovery_csr_file.sv */
// Recovery register storage with gated writes, protocol status update and registered read
`timescale 1ns/1ns

module recovery_csr_file (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  recovery_csr_pkg::csr_idx_e       csr_sel_i,
  input  logic                             csr_we_i,
  input  recovery_csr_pkg::csr_word_t      csr_wdata_i,
  output recovery_csr_pkg::csr_word_t      csr_rdata_o,
  input  logic                             status_we_i,
  input  recovery_pkg::protocol_error_e    status_code_i,
  output recovery_csr_pkg::csr_word_t      device_reset_o,
  output recovery_csr_pkg::csr_word_t      recovery_ctrl_o,
  output recovery_csr_pkg::csr_word_t      fifo_ctrl_0_o,
  output recovery_csr_pkg::csr_word_t      fifo_ctrl_1_o
);
  import recovery_csr_pkg::*;

  csr_word_t words_q [CSR_NUM_WORDS];
  logic      wr_en;

  // Writes to read-only words are silently dropped here
  assign wr_en = csr_we_i & CSR_WRITABLE[csr_sel_i];

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int i = 0; i < CSR_NUM_WORDS; i++) begin
        words_q[i] <= CSR_RESET[i];
      end
    end else begin
      if (wr_en)
        words_q[csr_sel_i] <= csr_wdata_i;
      // Protocol status byte of DEVICE_STATUS_0, other fields kept
      if (status_we_i)
        words_q[CSR_DEVICE_STATUS_0][15:8] <= status_code_i;
    end
  end

  // Read data follows the index one cycle later
  always_ff @(posedge clk_i) begin
    csr_rdata_o <= words_q[csr_sel_i];
  end

  assign device_reset_o  = words_q[CSR_DEVICE_RESET];
  assign recovery_ctrl_o = words_q[CSR_RECOVERY_CTRL];
  assign fifo_ctrl_0_o   = words_q[CSR_INDIRECT_FIFO_CTRL_0];
  assign fifo_ctrl_1_o   = words_q[CSR_INDIRECT_FIFO_CTRL_1];

endmodule

/* rtl/recovery_csr_pkg.sv */
// Recovery register map: word indices, word type, reset table, writable mask, start words
package recovery_csr_pkg;

  typedef logic [31:0] csr_word_t;

  localparam int CSR_NUM_WORDS = 25;

  typedef enum logic [4:0] {
    CSR_PROT_CAP_0, CSR_PROT_CAP_1, CSR_PROT_CAP_2, CSR_PROT_CAP_3,
    CSR_DEVICE_ID_0, CSR_DEVICE_ID_1, CSR_DEVICE_ID_2, CSR_DEVICE_ID_3,
    CSR_DEVICE_ID_4, CSR_DEVICE_ID_5, CSR_DEVICE_ID_6,
    CSR_DEVICE_STATUS_0, CSR_DEVICE_STATUS_1,
    CSR_DEVICE_RESET, CSR_RECOVERY_CTRL, CSR_RECOVERY_STATUS, CSR_HW_STATUS,
    CSR_INDIRECT_FIFO_CTRL_0, CSR_INDIRECT_FIFO_CTRL_1,
    CSR_INDIRECT_FIFO_STATUS_0, CSR_INDIRECT_FIFO_STATUS_1, CSR_INDIRECT_FIFO_STATUS_2,
    CSR_INDIRECT_FIFO_STATUS_3, CSR_INDIRECT_FIFO_STATUS_4, CSR_INDIRECT_FIFO_STATUS_5
  } csr_idx_e;

  typedef logic [CSR_NUM_WORDS-1:0][31:0] csr_table_t;

  // Word i resets to i * 0x01010101 + 0x00A50000
  function automatic csr_table_t csr_reset_table();
    csr_table_t table_v;
    for (int i = 0; i < CSR_NUM_WORDS; i++) begin
      table_v[i] = csr_word_t'(i) * 32'h0101_0101 + 32'h00A5_0000;
    end
    return table_v;
  endfunction

  localparam csr_table_t CSR_RESET = csr_reset_table();

  // Only the reset, recovery control and FIFO control words accept writes
  localparam logic [CSR_NUM_WORDS-1:0] CSR_WRITABLE =
    (25'd1 << CSR_DEVICE_RESET) | (25'd1 << CSR_RECOVERY_CTRL) |
    (25'd1 << CSR_INDIRECT_FIFO_CTRL_0) | (25'd1 << CSR_INDIRECT_FIFO_CTRL_1);

  // First word of each command's group, same order as the command codes
  localparam csr_idx_e CMD_START [9] = '{
    CSR_PROT_CAP_0, CSR_DEVICE_ID_0, CSR_DEVICE_STATUS_0, CSR_DEVICE_RESET,
    CSR_RECOVERY_CTRL, CSR_RECOVERY_STATUS, CSR_HW_STATUS,
    CSR_INDIRECT_FIFO_CTRL_0, CSR_INDIRECT_FIFO_STATUS_0
  };

endpackage

/* rtl/recovery_executor.sv */
// Recovery command executor: FSM, write word path, read byte stream and status update
`timescale 1ns/1ns

module recovery_executor (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Decoded command
  input  logic                          cmd_valid_i,
  input  logic                          cmd_is_rd_i,
  input  recovery_pkg::command_e        cmd_cmd_i,
  input  recovery_pkg::cmd_len_t        cmd_len_i,
  input  logic                          cmd_error_i,
  output logic                          cmd_done_o,
  // Response length and data streams
  output logic                          res_valid_o,
  input  logic                          res_ready_i,
  output recovery_pkg::cmd_len_t        res_len_o,
  output logic                          res_dvalid_o,
  input  logic                          res_dready_i,
  output recovery_pkg::res_byte_t       res_data_o,
  output logic                          res_dlast_o,
  // Receive word queue
  output logic                          rx_req_o,
  input  logic                          rx_ack_i,
  input  recovery_csr_pkg::csr_word_t   rx_data_i,
  output logic                          rx_queue_clr_o,
  input  logic                          host_abort_i,
  // Register file
  output recovery_csr_pkg::csr_idx_e    csr_sel_o,
  output logic                          csr_we_o,
  output recovery_csr_pkg::csr_word_t   csr_wdata_o,
  input  recovery_csr_pkg::csr_word_t   csr_rdata_i,
  output logic                          status_we_o,
  output recovery_pkg::protocol_error_e status_code_o
);
  import recovery_pkg::*;
  import recovery_csr_pkg::*;

  typedef enum logic [2:0] {
    Idle,
    CsrWrite,
    CsrRead,
    CsrReadLen,
    CsrReadData,
    Error,
    Done
  } state_e;

  state_e          state_q, state_d;
  logic [3:0]      dec_slot;
  logic            dec_known;
  csr_idx_e        dec_start;
  cmd_len_t        dec_len;
  logic [2:0]      dec_group;
  cmd_len_t        wr_words;
  protocol_error_e dec_code;
  csr_idx_e        idx_q;
  csr_idx_e        next_idx;
  cmd_len_t        len_q;
  cmd_len_t        dcnt_q;
  logic [1:0]      bcnt_q;
  logic [2:0]      group_q;
  protocol_error_e code_q;
  logic            wr_beat;
  logic            rd_beat;
  logic            in_group;

  // Command code to table slot
  always_comb begin
    dec_slot  = 4'd0;
    dec_known = 1'b1;
    case (cmd_cmd_i)
      CMD_PROT_CAP:             dec_slot = 4'd0;
      CMD_DEVICE_ID:            dec_slot = 4'd1;
      CMD_DEVICE_STATUS:        dec_slot = 4'd2;
      CMD_DEVICE_RESET:         dec_slot = 4'd3;
      CMD_RECOVERY_CTRL:        dec_slot = 4'd4;
      CMD_RECOVERY_STATUS:      dec_slot = 4'd5;
      CMD_HW_STATUS:            dec_slot = 4'd6;
      CMD_INDIRECT_FIFO_CTRL:   dec_slot = 4'd7;
      CMD_INDIRECT_FIFO_STATUS: dec_slot = 4'd8;
      default:                  dec_known = 1'b0;
    endcase
  end

  assign dec_start = CMD_START[dec_slot];
  assign dec_len   = CMD_LEN[dec_slot];
  // Words in the group, also the write limit
  assign dec_group = 3'((dec_len + 16'd3) >> 2);
  assign wr_words  = (cmd_len_i >> 2) + cmd_len_t'(|cmd_len_i[1:0]);

  // Status code known at command start
  always_comb begin
    if (cmd_error_i)
      dec_code = PROTOCOL_ERROR_CRC;
    else if (!dec_known)
      dec_code = PROTOCOL_ERROR_PARAMETER;
    else if (!cmd_is_rd_i && wr_words != '0 && !CSR_WRITABLE[dec_start])
      dec_code = PROTOCOL_ERROR_READ_ONLY;
    else
      dec_code = PROTOCOL_OK;
  end

  assign wr_beat  = rx_req_o & rx_ack_i;
  assign rd_beat  = res_dvalid_o & res_dready_i;
  assign in_group = (group_q != 3'd0);
  assign next_idx = csr_idx_e'(idx_q + 5'd1);

  always_comb begin
    state_d = state_q;
    case (state_q)
      Idle:
        if (cmd_valid_i) begin
          if (cmd_error_i || !dec_known)
            state_d = Error;
          else if (cmd_is_rd_i)
            state_d = CsrRead;
          else if (wr_words == '0)
            state_d = Done;
          else
            state_d = CsrWrite;
        end
      CsrWrite:
        if (wr_beat && dcnt_q == 16'd1)
          state_d = Done;
      CsrRead:     state_d = CsrReadLen;
      CsrReadLen:
        if (res_ready_i)
          state_d = CsrReadData;
      CsrReadData:
        if (host_abort_i)
          state_d = Error;
        else if (rd_beat && dcnt_q == 16'd1)
          state_d = Done;
      Error:       state_d = Done;
      default:     state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q     <= Idle;
      idx_q       <= CSR_PROT_CAP_0;
      len_q       <= '0;
      dcnt_q      <= '0;
      bcnt_q      <= '0;
      group_q     <= '0;
      code_q      <= PROTOCOL_OK;
      res_valid_o <= 1'b0;
    end else begin
      state_q     <= state_d;
      res_valid_o <= (state_q == CsrReadLen) && res_ready_i;
      case (state_q)
        Idle: begin
          bcnt_q <= '0;
          if (cmd_valid_i) begin
            idx_q   <= dec_start;
            len_q   <= dec_len;
            group_q <= dec_group;
            dcnt_q  <= cmd_is_rd_i ? dec_len : wr_words;
            code_q  <= dec_code;
          end
        end
        CsrWrite:
          if (wr_beat) begin
            dcnt_q <= dcnt_q - 16'd1;
            if (in_group) begin
              group_q <= group_q - 3'd1;
              idx_q   <= next_idx;
            end else if (code_q == PROTOCOL_OK) begin
              // Payload overruns the group, drained but not stored
              code_q <= PROTOCOL_ERROR_LENGTH;
            end
          end
        CsrReadData:
          if (rd_beat) begin
            dcnt_q <= dcnt_q - 16'd1;
            bcnt_q <= bcnt_q + 2'd1;
            idx_q  <= csr_sel_o;
          end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == CsrReadLen && res_ready_i)
      res_len_o <= len_q;
  end

  // Look ahead on the last byte so the next word is read in time
  assign csr_sel_o = (rd_beat && bcnt_q == 2'd3) ? next_idx : idx_q;
  assign csr_we_o    = wr_beat & in_group;
  assign csr_wdata_o = rx_data_i;

  assign rx_req_o       = (state_q == CsrWrite);
  assign rx_queue_clr_o = (state_q == Error);

  assign res_dvalid_o = (state_q == CsrReadData);
  assign res_data_o   = csr_rdata_i[8*bcnt_q +: 8];
  assign res_dlast_o  = res_dvalid_o & (dcnt_q == 16'd1);

  assign cmd_done_o    = (state_q == Done);
  assign status_we_o   = (state_q == Done);
  assign status_code_o = code_q;

endmodule

/* rtl/recovery_pkg.sv */
// Recovery protocol command codes, error codes, response lengths and byte types
package recovery_pkg;

  // Byte count of a command payload or response
  typedef logic [15:0] cmd_len_t;

  // One byte of the response data stream
  typedef logic [7:0] res_byte_t;

  // Recovery command codes handled by the executor
  typedef enum logic [7:0] {
    CMD_PROT_CAP             = 8'd34,
    CMD_DEVICE_ID            = 8'd35,
    CMD_DEVICE_STATUS        = 8'd36,
    CMD_DEVICE_RESET         = 8'd37,
    CMD_RECOVERY_CTRL        = 8'd38,
    CMD_RECOVERY_STATUS      = 8'd39,
    CMD_HW_STATUS            = 8'd40,
    CMD_INDIRECT_FIFO_CTRL   = 8'd45,
    CMD_INDIRECT_FIFO_STATUS = 8'd46
  } command_e;

  // Protocol status byte reported in DEVICE_STATUS
  typedef enum logic [7:0] {
    PROTOCOL_OK              = 8'h00,
    PROTOCOL_ERROR_READ_ONLY = 8'h01,
    PROTOCOL_ERROR_PARAMETER = 8'h02,
    PROTOCOL_ERROR_LENGTH    = 8'h03,
    PROTOCOL_ERROR_CRC       = 8'h04
  } protocol_error_e;

  localparam int CMD_NUM = 9;

  // Response length in bytes, same order as command_e
  localparam cmd_len_t CMD_LEN [CMD_NUM] = '{
    16'd15, 16'd24, 16'd8, 16'd3, 16'd3, 16'd2, 16'd4, 16'd6, 16'd20
  };

endpackage

/* rtl/recovery_top.sv */
// Recovery target top: receive queue, command executor and register file
`timescale 1ns/1ns

module recovery_top (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        cmd_valid_i,
  input  logic                        cmd_is_rd_i,
  input  recovery_pkg::command_e      cmd_cmd_i,
  input  recovery_pkg::cmd_len_t      cmd_len_i,
  input  logic                        cmd_error_i,
  output logic                        cmd_done_o,
  output logic                        res_valid_o,
  input  logic                        res_ready_i,
  output recovery_pkg::cmd_len_t      res_len_o,
  output logic                        res_dvalid_o,
  input  logic                        res_dready_i,
  output recovery_pkg::res_byte_t     res_data_o,
  output logic                        res_dlast_o,
  input  logic                        rx_wvalid_i,
  input  recovery_csr_pkg::csr_word_t rx_wdata_i,
  output logic                        rx_full_o,
  output logic                        rx_empty_o,
  output logic                        rx_req_o,
  output logic                        rx_queue_clr_o,
  input  logic                        host_abort_i,
  output recovery_csr_pkg::csr_word_t device_reset_o,
  output recovery_csr_pkg::csr_word_t recovery_ctrl_o,
  output recovery_csr_pkg::csr_word_t fifo_ctrl_0_o,
  output recovery_csr_pkg::csr_word_t fifo_ctrl_1_o
);
  import recovery_pkg::*;
  import recovery_csr_pkg::*;

  logic            rx_ack;
  csr_word_t       rx_data;
  csr_idx_e        csr_sel;
  logic            csr_we;
  csr_word_t       csr_wdata;
  csr_word_t       csr_rdata;
  logic            status_we;
  protocol_error_e status_code;

  rx_word_queue u_rx_queue (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (rx_wvalid_i),
    .push_data_i (rx_wdata_i),
    .full_o      (rx_full_o),
    .empty_o     (rx_empty_o),
    .pop_req_i   (rx_req_o),
    .pop_ack_o   (rx_ack),
    .pop_data_o  (rx_data),
    .clr_i       (rx_queue_clr_o)
  );

  recovery_executor u_executor (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .cmd_valid_i    (cmd_valid_i),
    .cmd_is_rd_i    (cmd_is_rd_i),
    .cmd_cmd_i      (cmd_cmd_i),
    .cmd_len_i      (cmd_len_i),
    .cmd_error_i    (cmd_error_i),
    .cmd_done_o     (cmd_done_o),
    .res_valid_o    (res_valid_o),
    .res_ready_i    (res_ready_i),
    .res_len_o      (res_len_o),
    .res_dvalid_o   (res_dvalid_o),
    .res_dready_i   (res_dready_i),
    .res_data_o     (res_data_o),
    .res_dlast_o    (res_dlast_o),
    .rx_req_o       (rx_req_o),
    .rx_ack_i       (rx_ack),
    .rx_data_i      (rx_data),
    .rx_queue_clr_o (rx_queue_clr_o),
    .host_abort_i   (host_abort_i),
    .csr_sel_o      (csr_sel),
    .csr_we_o       (csr_we),
    .csr_wdata_o    (csr_wdata),
    .csr_rdata_i    (csr_rdata),
    .status_we_o    (status_we),
    .status_code_o  (status_code)
  );

  recovery_csr_file u_csr_file (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .csr_sel_i       (csr_sel),
    .csr_we_i        (csr_we),
    .csr_wdata_i     (csr_wdata),
    .csr_rdata_o     (csr_rdata),
    .status_we_i     (status_we),
    .status_code_i   (status_code),
    .device_reset_o  (device_reset_o),
    .recovery_ctrl_o (recovery_ctrl_o),
    .fifo_ctrl_0_o   (fifo_ctrl_0_o),
    .fifo_ctrl_1_o   (fifo_ctrl_1_o)
  );

endmodule

/* rtl/rx_word_queue.sv */
// Four-entry receive word queue with push, req/ack pop and clear
`timescale 1ns/1ns

module rx_word_queue (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        push_i,
  input  recovery_csr_pkg::csr_word_t push_data_i,
  output logic                        full_o,
  output logic                        empty_o,
  input  logic                        pop_req_i,
  output logic                        pop_ack_o,
  output recovery_csr_pkg::csr_word_t pop_data_o,
  input  logic                        clr_i
);
  import recovery_csr_pkg::*;

  csr_word_t  mem_q [4];
  logic [1:0] wr_ptr_q;
  logic [1:0] rd_ptr_q;
  logic [2:0] count_q;
  logic       push;
  logic       pop;

  assign full_o     = (count_q == 3'd4);
  assign empty_o    = (count_q == 3'd0);
  // Pushes into a full queue are dropped
  assign push       = push_i & ~full_o;
  assign pop        = pop_req_i & ~empty_o;
  assign pop_ack_o  = pop;
  assign pop_data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clr_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      wr_ptr_q <= wr_ptr_q + 2'(push);
      rd_ptr_q <= rd_ptr_q + 2'(pop);
      count_q  <= count_q + 3'(push) - 3'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push)
      mem_q[wr_ptr_q] <= push_data_i;
  end

endmodule

/* sources.f */
+incdir+dv
rtl/recovery_pkg.sv
rtl/recovery_csr_pkg.sv
rtl/rx_word_queue.sv
rtl/recovery_csr_file.sv
rtl/recovery_executor.sv
rtl/recovery_top.sv
dv/tb_clk_gen.sv
dv/recovery_checker.sv
dv/tb_recovery.sv
